// File: apb_pkg.sv
`default_nettype none

package apb_pkg;

    // APB bus widths.
    localparam int addr_width = 32;
    localparam int data_width = 32;
    localparam int strb_width = data_width / 8;

    // Address bit that picks the slave.
    // Zero selects GPIO, one selects the display.
    localparam int sel_bit = 12;
    localparam logic sel_gpio = 1'b0;
    localparam logic sel_display = 1'b1;

    // Low address bits decoded inside a slave.
    localparam int offset_width = 4;

endpackage

`default_nettype wire

// File: periph_pkg.sv
`default_nettype none

package periph_pkg;

    // GPIO register offsets.
    localparam logic [apb_pkg::offset_width-1:0] gpio_out_offset = 'h0;
    localparam logic [apb_pkg::offset_width-1:0] gpio_in_offset = 'h4;
    localparam logic [apb_pkg::offset_width-1:0] blank_offset = 'h8;

    // Display register offset.
    localparam logic [apb_pkg::offset_width-1:0] digits_offset = 'h0;

    localparam int gpio_width = 16;
    localparam int digit_count = 8;

    // Reset values.
    localparam logic [gpio_width-1:0] gpio_out_reset = '0;
    localparam logic [digit_count-1:0] blank_reset = '0;

    // Dark digit, all segments and dp off.
    localparam logic [7:0] seg_blank = 8'hff;

    // Active low, bit 7 is segment a down to bit 0 for dp.
    localparam logic [7:0] seg_table [16] = '{
        8'b0000_0011, 8'b1001_1111, 8'b0010_0101, 8'b0000_1101,
        8'b1001_1001, 8'b0100_1001, 8'b0100_0001, 8'b0001_1111,
        8'b0000_0001, 8'b0000_1001, 8'b0001_0001, 8'b1100_0001,
        8'b0110_0011, 8'b1000_0101, 8'b0110_0001, 8'b0111_0001
    };

endpackage

`default_nettype wire

// File: apb_if.sv
`timescale 1ns/10ps
`default_nettype none

interface apb_if (
    input wire logic clock,
    input wire logic reset
);

    logic [apb_pkg::addr_width-1:0] paddr;
    logic psel;
    logic penable;
    logic pwrite;
    logic [apb_pkg::data_width-1:0] pwdata;
    logic [apb_pkg::strb_width-1:0] pstrb;
    logic pready;
    logic [apb_pkg::data_width-1:0] prdata;
    logic pslverr;

    modport requester (
        input clock, reset,
        output paddr, psel, penable, pwrite, pwdata, pstrb,
        input pready, prdata, pslverr
    );

    modport completer (
        input clock, reset,
        input paddr, psel, penable, pwrite, pwdata, pstrb,
        output pready, prdata, pslverr
    );

endinterface

`default_nettype wire

// File: apb_splitter.sv
`timescale 1ns/10ps
`default_nettype none

module apb_splitter (
    apb_if.completer host,
    apb_if.requester gpio_bus,
    apb_if.requester display_bus
);

    logic slave_sel;

    assign slave_sel = host.paddr[apb_pkg::sel_bit];

    // Request fields go to both slaves.
    assign gpio_bus.paddr = host.paddr;
    assign gpio_bus.penable = host.penable;
    assign gpio_bus.pwrite = host.pwrite;
    assign gpio_bus.pwdata = host.pwdata;
    assign gpio_bus.pstrb = host.pstrb;

    assign display_bus.paddr = host.paddr;
    assign display_bus.penable = host.penable;
    assign display_bus.pwrite = host.pwrite;
    assign display_bus.pwdata = host.pwdata;
    assign display_bus.pstrb = host.pstrb;

    // Only the addressed slave sees psel.
    assign gpio_bus.psel = host.psel && (slave_sel == apb_pkg::sel_gpio);
    assign display_bus.psel = host.psel && (slave_sel == apb_pkg::sel_display);

    // Response from the addressed slave.
    always_comb begin
        if (slave_sel == apb_pkg::sel_display) begin
            host.pready = display_bus.pready;
            host.prdata = display_bus.prdata;
            host.pslverr = display_bus.pslverr;
        end else begin
            host.pready = gpio_bus.pready;
            host.prdata = gpio_bus.prdata;
            host.pslverr = gpio_bus.pslverr;
        end
    end

    // Requester keeps psel up through the access cycle.
    host_penable_needs_psel : assert property (
        @(posedge host.clock) disable iff (host.reset)
        host.penable |-> host.psel
    ) else $error("penable high without psel");

    // A slave answers only when it is the one addressed.
    gpio_ready_selected : assert property (
        @(posedge host.clock) disable iff (host.reset)
        $rose(gpio_bus.pready) |-> gpio_bus.psel
    ) else $error("GPIO pready rose while unselected");

    display_ready_selected : assert property (
        @(posedge host.clock) disable iff (host.reset)
        $rose(display_bus.pready) |-> display_bus.psel
    ) else $error("display pready rose while unselected");

endmodule

`default_nettype wire

// File: gpio_regs.sv
`timescale 1ns/10ps
`default_nettype none

module gpio_regs (
    input wire logic clock,
    input wire logic reset,
    apb_if.completer bus,
    input wire logic [periph_pkg::gpio_width-1:0] gpio_in,
    output logic [periph_pkg::gpio_width-1:0] gpio_out,
    output logic [periph_pkg::digit_count-1:0] blank_mask
);

    logic [apb_pkg::offset_width-1:0] offset;
    logic access;
    logic write_en;
    logic mapped;
    logic [periph_pkg::gpio_width-1:0] in_meta;
    logic [periph_pkg::gpio_width-1:0] in_sync;
    logic [apb_pkg::data_width-1:0] rdata;

    assign offset = bus.paddr[apb_pkg::offset_width-1:0];
    assign access = bus.psel && bus.penable;
    assign write_en = access && bus.pwrite;

    // Zero wait states.
    assign bus.pready = access;

    // Output register, byte lanes 0 and 1.
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            gpio_out <= periph_pkg::gpio_out_reset;
        end else if (write_en && offset == periph_pkg::gpio_out_offset) begin
            for (int k = 0; k < periph_pkg::gpio_width / 8; k++) begin
                if (bus.pstrb[k]) begin
                    gpio_out[8*k +: 8] <= bus.pwdata[8*k +: 8];
                end
            end
        end
    end

    // Blanking mask, byte lane 0.
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            blank_mask <= periph_pkg::blank_reset;
        end else if (write_en && offset == periph_pkg::blank_offset && bus.pstrb[0]) begin
            blank_mask <= bus.pwdata[periph_pkg::digit_count-1:0];
        end
    end

    // Two-flop input synchronizer.
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            in_meta <= '0;
            in_sync <= '0;
        end else begin
            in_meta <= gpio_in;
            in_sync <= in_meta;
        end
    end

    always_comb begin
        rdata = '0;
        mapped = 1'b1;
        case (offset)
            periph_pkg::gpio_out_offset: rdata[periph_pkg::gpio_width-1:0] = gpio_out;
            periph_pkg::gpio_in_offset: rdata[periph_pkg::gpio_width-1:0] = in_sync;
            periph_pkg::blank_offset: rdata[periph_pkg::digit_count-1:0] = blank_mask;
            default: mapped = 1'b0;
        endcase
    end

    assign bus.prdata = rdata;

    // Input register is read only.
    assign bus.pslverr = access &&
        (!mapped || (bus.pwrite && offset == periph_pkg::gpio_in_offset));

    // An error answer ends a transfer that had a proper setup cycle.
    slverr_in_access : assert property (
        @(posedge clock) disable iff (reset)
        bus.pslverr |-> bus.penable && $past(bus.psel && !bus.penable)
    ) else $error("GPIO pslverr outside an access cycle");

endmodule

`default_nettype wire

// File: seg_display.sv
`timescale 1ns/10ps
`default_nettype none

module seg_display (
    input wire logic clock,
    input wire logic reset,
    apb_if.completer bus,
    input wire logic [periph_pkg::digit_count-1:0] blank_mask,
    output logic [8*periph_pkg::digit_count-1:0] segments
);

    logic [apb_pkg::offset_width-1:0] offset;
    logic access;
    logic hit;
    logic [3:0] digit [periph_pkg::digit_count];
    logic [periph_pkg::digit_count-1:0] loaded;
    logic [apb_pkg::data_width-1:0] packed_digits;

    assign offset = bus.paddr[apb_pkg::offset_width-1:0];
    assign access = bus.psel && bus.penable;
    assign hit = offset == periph_pkg::digits_offset;

    assign bus.pready = access;

    // Lane k loads digits 2k and 2k+1, low nibble to the even digit.
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            loaded <= '0;
            for (int i = 0; i < periph_pkg::digit_count; i++) begin
                digit[i] <= '0;
            end
        end else if (access && bus.pwrite && hit) begin
            for (int k = 0; k < apb_pkg::strb_width; k++) begin
                if (bus.pstrb[k]) begin
                    digit[2*k] <= bus.pwdata[8*k +: 4];
                    digit[2*k+1] <= bus.pwdata[8*k+4 +: 4];
                    loaded[2*k] <= 1'b1;
                    loaded[2*k+1] <= 1'b1;
                end
            end
        end
    end

    always_comb begin
        packed_digits = '0;
        for (int i = 0; i < periph_pkg::digit_count; i++) begin
            packed_digits[4*i +: 4] = digit[i];
        end
    end

    assign bus.prdata = hit ? packed_digits : '0;
    assign bus.pslverr = access && !hit;

    // Static drive, one byte per digit.
    for (genvar i = 0; i < periph_pkg::digit_count; i++) begin : g_digit
        assign segments[8*i +: 8] = (!loaded[i] || blank_mask[i]) ?
            periph_pkg::seg_blank : periph_pkg::seg_table[digit[i]];

        // A strobed write loads the digit and marks it shown.
        write_loads_digit : assert property (
            @(posedge clock) disable iff (reset)
            access && bus.pwrite && hit && bus.pstrb[i / 2] |=>
                loaded[i] && digit[i] == $past(bus.pwdata[4*i +: 4])
        ) else $error("digit %0d not loaded by its write", i);
    end

endmodule

`default_nettype wire

// File: periph_top.sv
`timescale 1ns/10ps
`default_nettype none

module periph_top (
    input wire logic clock,
    input wire logic reset,

    input wire logic [apb_pkg::addr_width-1:0] paddr,
    input wire logic psel,
    input wire logic penable,
    input wire logic [2:0] pprot,
    input wire logic pwrite,
    input wire logic [apb_pkg::data_width-1:0] pwdata,
    input wire logic [apb_pkg::strb_width-1:0] pstrb,
    output logic pready,
    output logic [apb_pkg::data_width-1:0] prdata,
    output logic pslverr,

    input wire logic [periph_pkg::gpio_width-1:0] gpio_in,
    output logic [periph_pkg::gpio_width-1:0] gpio_out,
    output logic [8*periph_pkg::digit_count-1:0] segments
);

    apb_if host_bus (.clock(clock), .reset(reset));
    apb_if gpio_bus (.clock(clock), .reset(reset));
    apb_if display_bus (.clock(clock), .reset(reset));

    logic [periph_pkg::digit_count-1:0] blank_mask;

    // Host pins onto the bus; pprot is not checked.
    assign host_bus.paddr = paddr;
    assign host_bus.psel = psel;
    assign host_bus.penable = penable;
    assign host_bus.pwrite = pwrite;
    assign host_bus.pwdata = pwdata;
    assign host_bus.pstrb = pstrb;

    assign pready = host_bus.pready;
    assign prdata = host_bus.prdata;
    assign pslverr = host_bus.pslverr;

    apb_splitter i_splitter (
        .host        (host_bus.completer),
        .gpio_bus    (gpio_bus.requester),
        .display_bus (display_bus.requester)
    );

    gpio_regs i_gpio (
        .clock      (clock),
        .reset      (reset),
        .bus        (gpio_bus.completer),
        .gpio_in    (gpio_in),
        .gpio_out   (gpio_out),
        .blank_mask (blank_mask)
    );

    seg_display i_display (
        .clock      (clock),
        .reset      (reset),
        .bus        (display_bus.completer),
        .blank_mask (blank_mask),
        .segments   (segments)
    );

endmodule

`default_nettype wire

// File: tb_periph.sv
`timescale 1ns/10ps
`default_nettype none

module tb_periph;

    localparam int clock_period = 10;
    localparam int reset_cycles = 16;
    localparam int gpio_rounds = 20;
    localparam int input_rounds = 8;
    localparam int digit_rounds = 16;
    localparam int blank_rounds = 12;
    localparam int mixed_rounds = 60;
    // Idle gaps of the input rounds are budgeted as one extra transfer.
    localparam int transfer_count = 4 + 2 * gpio_rounds + 2 * input_rounds
        + 2 * digit_rounds + 1 + 2 * blank_rounds + 2 + mixed_rounds + 4;
    localparam int margin_cycles = 200;
    localparam logic [31:0] display_base = 32'h0000_1000;

    // Active low, a in bit 7 down to dp in bit 0.
    localparam logic [7:0] hex_segments [16] = '{
        8'h03, 8'h9f, 8'h25, 8'h0d, 8'h99, 8'h49, 8'h41, 8'h1f,
        8'h01, 8'h09, 8'h11, 8'hc1, 8'h63, 8'h85, 8'h61, 8'h71
    };

    logic clock;
    logic reset;
    logic [31:0] paddr;
    logic psel;
    logic penable;
    logic [2:0] pprot;
    logic pwrite;
    logic [31:0] pwdata;
    logic [3:0] pstrb;
    logic pready;
    logic [31:0] prdata;
    logic pslverr;
    logic [15:0] gpio_in;
    logic [15:0] gpio_out;
    logic [63:0] segments;

    logic [31:0] lfsr_state;
    int errors;
    int checks;

    // Reference model state.
    logic [15:0] m_gpio_out;
    logic [15:0] m_gpio_in;
    logic [7:0] m_mask;
    logic [3:0] m_digit [8];
    logic [7:0] m_loaded;

    periph_top i_dut (
        .clock    (clock),
        .reset    (reset),
        .paddr    (paddr),
        .psel     (psel),
        .penable  (penable),
        .pprot    (pprot),
        .pwrite   (pwrite),
        .pwdata   (pwdata),
        .pstrb    (pstrb),
        .pready   (pready),
        .prdata   (prdata),
        .pslverr  (pslverr),
        .gpio_in  (gpio_in),
        .gpio_out (gpio_out),
        .segments (segments)
    );

    initial begin
        clock = 1'b0;
        forever #(clock_period / 2) clock = ~clock;
    end

    initial begin
        #((transfer_count * 4 + reset_cycles + margin_cycles) * clock_period);
        $display("Timeout: the tests did not finish within the expected time");
        $display("Some tests failed");
        $finish;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 32'h8020_0003;
        end
        return state >> 1;
    endfunction

    task automatic random_bits(input int count, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value = {value[30:0], lfsr_state[0]};
        end
    endtask

    task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                               input string what);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Mismatch at %0t ns: %s, got %h, expected %h",
                     $time, what, actual, expected);
        end
    endtask

    function automatic logic [63:0] expected_segments();
        logic [63:0] seg;
        seg = '0;
        for (int i = 0; i < 8; i++) begin
            if (m_loaded[i] && !m_mask[i]) begin
                seg[8*i +: 8] = hex_segments[m_digit[i]];
            end else begin
                seg[8*i +: 8] = 8'hff;
            end
        end
        return seg;
    endfunction

    task automatic model_access(input logic write, input logic [31:0] addr,
                                input logic [31:0] data, input logic [3:0] strb,
                                output logic [31:0] rdata, output logic err);
        logic [3:0] offset;
        offset = addr[3:0];
        rdata = '0;
        err = 1'b0;
        if (addr[12]) begin
            if (offset != 4'h0) begin
                err = 1'b1;
            end else if (write) begin
                for (int k = 0; k < 4; k++) begin
                    if (strb[k]) begin
                        m_digit[2*k] = data[8*k +: 4];
                        m_digit[2*k+1] = data[8*k+4 +: 4];
                        m_loaded[2*k] = 1'b1;
                        m_loaded[2*k+1] = 1'b1;
                    end
                end
            end else begin
                for (int i = 0; i < 8; i++) begin
                    rdata[4*i +: 4] = m_digit[i];
                end
            end
        end else begin
            case (offset)
                4'h0: begin
                    if (!write) begin
                        rdata[15:0] = m_gpio_out;
                    end else begin
                        if (strb[0]) m_gpio_out[7:0] = data[7:0];
                        if (strb[1]) m_gpio_out[15:8] = data[15:8];
                    end
                end
                4'h4: begin
                    if (write) begin
                        err = 1'b1;
                    end else begin
                        rdata[15:0] = m_gpio_in;
                    end
                end
                4'h8: begin
                    if (!write) begin
                        rdata[7:0] = m_mask;
                    end else if (strb[0]) begin
                        m_mask = data[7:0];
                    end
                end
                default: err = 1'b1;
            endcase
        end
    endtask

    // Setup cycle, then a single access cycle.
    task automatic apb_transfer(input logic write, input logic [31:0] addr,
                                input logic [31:0] data, input logic [3:0] strb,
                                output logic [31:0] rdata, output logic err);
        @(posedge clock);
        paddr <= addr;
        psel <= 1'b1;
        penable <= 1'b0;
        pwrite <= write;
        pwdata <= data;
        pstrb <= write ? strb : 4'h0;
        @(posedge clock);
        penable <= 1'b1;
        @(negedge clock);
        check_value(64'(pready), 64'd1, "pready in the access cycle");
        rdata = prdata;
        err = pslverr;
        @(posedge clock);
        psel <= 1'b0;
        penable <= 1'b0;
        pwrite <= 1'b0;
    endtask

    task automatic access_and_check(input logic write, input logic [31:0] addr,
                                    input logic [31:0] data, input logic [3:0] strb);
        logic [31:0] got_data;
        logic got_err;
        logic [31:0] exp_data;
        logic exp_err;
        model_access(write, addr, data, strb, exp_data, exp_err);
        apb_transfer(write, addr, data, strb, got_data, got_err);
        check_value(64'(got_err), 64'(exp_err), $sformatf("pslverr at address %h", addr));
        if (!write) begin
            check_value(64'(got_data), 64'(exp_data), $sformatf("read data at %h", addr));
        end
    endtask

    task automatic check_pins();
        @(negedge clock);
        check_value(64'(pready), 64'd0, "pready while idle");
        check_value(64'(gpio_out), 64'(m_gpio_out), "gpio_out pins");
        check_value(segments, expected_segments(), "segment outputs");
    endtask

    initial begin
        logic [31:0] r;
        logic [31:0] addr;
        logic [31:0] data;
        logic write;
        lfsr_state = 32'h8511;
        errors = 0;
        checks = 0;
        reset = 1'b1;
        paddr = '0;
        psel = 1'b0;
        penable = 1'b0;
        pprot = 3'b000;
        pwrite = 1'b0;
        pwdata = '0;
        pstrb = '0;
        gpio_in = '0;
        m_gpio_out = '0;
        m_gpio_in = '0;
        m_mask = '0;
        m_loaded = '0;
        for (int i = 0; i < 8; i++) begin
            m_digit[i] = 4'h0;
        end

        repeat (reset_cycles) @(posedge clock);
        reset <= 1'b0;

        // State after reset.
        check_pins();
        access_and_check(1'b0, 32'h0, '0, '0);
        access_and_check(1'b0, 32'h4, '0, '0);
        access_and_check(1'b0, 32'h8, '0, '0);
        access_and_check(1'b0, display_base, '0, '0);

        for (int n = 0; n < gpio_rounds; n++) begin
            random_bits(32, data);
            random_bits(4, r);
            access_and_check(1'b1, 32'h0, data, r[3:0]);
            check_pins();
            access_and_check(1'b0, 32'h0, '0, '0);
        end

        // Two synchronizer edges, plus one spare.
        for (int n = 0; n < input_rounds; n++) begin
            random_bits(16, r);
            @(posedge clock);
            gpio_in <= r[15:0];
            repeat (3) @(posedge clock);
            m_gpio_in = r[15:0];
            access_and_check(1'b0, 32'h4, '0, '0);
        end

        for (int n = 0; n < digit_rounds; n++) begin
            random_bits(32, data);
            random_bits(4, r);
            access_and_check(1'b1, display_base, data, r[3:0]);
            check_pins();
            access_and_check(1'b0, display_base, '0, '0);
        end

        // Every digit loaded before masking.
        random_bits(32, data);
        access_and_check(1'b1, display_base, data, 4'hf);

        for (int n = 0; n < blank_rounds; n++) begin
            random_bits(8, r);
            access_and_check(1'b1, 32'h8, {24'h0, r[7:0]}, 4'h1);
            check_pins();
            access_and_check(1'b0, 32'h8, '0, '0);
        end
        access_and_check(1'b1, 32'h8, 32'h0, 4'hf);
        check_pins();
        access_and_check(1'b0, 32'h8, '0, '0);

        // Mixed traffic, unmapped offsets included.
        for (int n = 0; n < mixed_rounds; n++) begin
            random_bits(1, r);
            addr = r[0] ? display_base : 32'h0;
            random_bits(1, r);
            if (r[0]) begin
                random_bits(2, r);
                addr[3:0] = {r[1:0], 2'b00};
            end else begin
                random_bits(4, r);
                addr[3:0] = r[3:0];
            end
            random_bits(1, r);
            write = r[0];
            random_bits(4, r);
            random_bits(32, data);
            access_and_check(write, addr, data, r[3:0]);
            check_pins();
        end

        access_and_check(1'b0, 32'h0, '0, '0);
        access_and_check(1'b0, 32'h4, '0, '0);
        access_and_check(1'b0, 32'h8, '0, '0);
        access_and_check(1'b0, display_base, '0, '0);

        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
apb_pkg.sv
periph_pkg.sv
apb_if.sv
apb_splitter.sv
gpio_regs.sv
seg_display.sv
periph_top.sv
tb_periph.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing
TOP ?= tb_periph
FILELIST ?= verilog.f
OBJ_DIR ?= obj_dir
PASS_TEXT ?= All tests passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
